// ==== atm_pkg.sv ====
package atm_pkg;

    localparam int num_accounts = 4;
    localparam int max_pin_tries = 3;

    // one bit of headroom so an overrun shows up in the counter
    localparam int pin_count_width = $clog2(max_pin_tries + 1) + 1;

    typedef logic [1:0] acct_index_t;
    typedef logic [15:0] card_number_t;
    typedef logic [15:0] pin_t;
    typedef logic [19:0] money_t;
    typedef logic [pin_count_width-1:0] pin_count_t;

    // reset account table
    localparam card_number_t card_table [num_accounts] = '{
        16'hC5AA, 16'h705C, 16'h3219, 16'h8629
    };

    localparam pin_t pin_table [num_accounts] = '{
        16'h1F5E, 16'h04BF, 16'h04D2, 16'h0D05
    };

    localparam money_t balance_reset_table [num_accounts] = '{
        20'd5000, 20'd8000, 20'd7500, 20'd3000
    };

    // 5 to 7 fall through as op_none
    typedef enum logic [2:0] {
        op_none     = 3'd0,
        op_exit     = 3'd1,
        op_balance  = 3'd2,
        op_withdraw = 3'd3,
        op_deposit  = 3'd4
    } opcode_e;

    typedef enum logic [3:0] {
        st_idle            = 4'd0,
        st_card_check      = 4'd1,
        st_pin_entry       = 4'd2,
        st_home            = 4'd3,
        st_withdraw_check  = 4'd4,
        st_withdraw_commit = 4'd5,
        st_deposit_wait    = 4'd6,
        st_deposit_commit  = 4'd7,
        st_show_balance    = 4'd8,
        st_another         = 4'd9,
        st_eject           = 4'd10
    } session_state_e;

    typedef struct packed {
        logic write;
        logic is_deposit; // add when set, else subtract
    } ledger_cmd_t;

    typedef struct packed {
        logic usage_finished;
        logic balance_shown;
        logic withdrew;
        logic deposited;
    } atm_status_t;

endpackage

// ==== account_ledger.sv ====
`timescale 1ns/1ps

module account_ledger (
    input  logic                   clk,
    input  logic                   reset,
    input  atm_pkg::card_number_t  card_number,
    output logic                   lookup_hit,
    output atm_pkg::acct_index_t   lookup_index,
    input  atm_pkg::acct_index_t   sel_index,
    input  atm_pkg::money_t        amount,
    input  atm_pkg::ledger_cmd_t   cmd,
    output atm_pkg::pin_t          stored_pin,
    output atm_pkg::money_t        balance,
    output logic                   withdraw_ok,
    output logic                   deposit_ok
);

    localparam int money_width = $bits(atm_pkg::money_t);

    atm_pkg::money_t balances [atm_pkg::num_accounts];

    logic [money_width:0]   deposit_sum; // extra bit catches the carry
    atm_pkg::money_t        withdraw_diff;
    atm_pkg::money_t        new_balance;

    // card numbers are unique so at most one entry hits
    always_comb begin
        lookup_hit = 1'b0;
        lookup_index = '0;
        for (int i = 0; i < atm_pkg::num_accounts; i++) begin
            if (atm_pkg::card_table[i] == card_number) begin
                lookup_hit = 1'b1;
                lookup_index = atm_pkg::acct_index_t'(i);
            end
        end
    end

    // selected account view
    assign stored_pin = atm_pkg::pin_table[sel_index];
    assign balance = balances[sel_index];

    assign deposit_sum = {1'b0, balance} + {1'b0, amount};
    assign withdraw_diff = balance - amount;

    assign withdraw_ok = (amount <= balance);
    assign deposit_ok = ~deposit_sum[money_width]; // no overflow

    assign new_balance = cmd.is_deposit ? deposit_sum[money_width-1:0] : withdraw_diff;

    // balances survive sessions, only reset reloads them
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < atm_pkg::num_accounts; i++) begin
                balances[i] <= atm_pkg::balance_reset_table[i];
            end
        end else if (cmd.write) begin
            balances[sel_index] <= new_balance;
        end
    end

    // a commit only follows a passed funds check
    property commit_is_funded;
        @(posedge clk) disable iff (!reset)
        cmd.write |-> (cmd.is_deposit ? deposit_ok : withdraw_ok);
    endproperty

    assert property (commit_is_funded)
        else $error("ledger write without a passing funds check");

endmodule

// ==== pin_guard.sv ====
`timescale 1ns/1ps

module pin_guard (
    input  logic            clk,
    input  logic            reset,
    input  logic            session_start,
    input  logic            pin_strobe,
    input  atm_pkg::pin_t   pin,
    input  atm_pkg::pin_t   stored_pin,
    output logic            pin_ok,
    output logic            pin_locked
);

    atm_pkg::pin_count_t fail_count;

    logic pin_match;
    logic pin_miss;
    logic last_try;

    assign pin_match = (pin == stored_pin);
    assign pin_miss = pin_strobe && !pin_match;

    // the try being judged now is the final one
    assign last_try = (fail_count == atm_pkg::pin_count_t'(atm_pkg::max_pin_tries - 1));

    assign pin_ok = pin_strobe && pin_match;
    assign pin_locked = pin_miss && last_try;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fail_count <= '0;
        end else if (session_start) begin
            fail_count <= '0; // fresh card, fresh tries
        end else if (pin_miss) begin
            fail_count <= fail_count + 1'b1;
        end
    end

    // the session has to stop strobing once the card is locked out
    property count_in_range;
        @(posedge clk) disable iff (!reset)
        fail_count <= atm_pkg::pin_count_t'(atm_pkg::max_pin_tries);
    endproperty

    assert property (count_in_range)
        else $error("pin failure count past the retry limit");

endmodule

// ==== session_fsm.sv ====
`timescale 1ns/1ps

module session_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   card_in,
    input  logic                   timer,
    input  atm_pkg::opcode_e       opcode,
    input  logic                   money_counted,
    input  logic                   another,
    input  logic                   lookup_hit,
    input  atm_pkg::acct_index_t   lookup_index,
    input  logic                   pin_ok,
    input  logic                   pin_locked,
    input  logic                   withdraw_ok,
    input  logic                   deposit_ok,
    output atm_pkg::acct_index_t   sel_index,
    output logic                   session_start,
    output atm_pkg::ledger_cmd_t   cmd,
    output atm_pkg::atm_status_t   status
);

    atm_pkg::session_state_e state;
    atm_pkg::session_state_e next_state;

    logic timer_abort;

    // idle has no card to eject, eject is already on its way out
    assign timer_abort = timer
        && (state != atm_pkg::st_idle)
        && (state != atm_pkg::st_eject);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= atm_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            atm_pkg::st_idle: begin
                if (card_in) begin
                    next_state = atm_pkg::st_card_check;
                end
            end
            atm_pkg::st_card_check: begin
                next_state = lookup_hit ? atm_pkg::st_pin_entry : atm_pkg::st_eject;
            end
            atm_pkg::st_pin_entry: begin
                if (pin_ok) begin
                    next_state = atm_pkg::st_home;
                end else if (pin_locked) begin
                    next_state = atm_pkg::st_eject;
                end
            end
            atm_pkg::st_home: begin
                case (opcode)
                    atm_pkg::op_exit:     next_state = atm_pkg::st_eject;
                    atm_pkg::op_balance:  next_state = atm_pkg::st_show_balance;
                    atm_pkg::op_withdraw: next_state = atm_pkg::st_withdraw_check;
                    atm_pkg::op_deposit:  next_state = atm_pkg::st_deposit_wait;
                    default:              next_state = atm_pkg::st_home; // op_none and 5..7
                endcase
            end
            atm_pkg::st_withdraw_check: begin
                next_state = withdraw_ok ? atm_pkg::st_withdraw_commit : atm_pkg::st_eject;
            end
            atm_pkg::st_deposit_wait: begin
                if (money_counted) begin
                    next_state = deposit_ok ? atm_pkg::st_deposit_commit : atm_pkg::st_eject;
                end
            end
            atm_pkg::st_withdraw_commit,
            atm_pkg::st_deposit_commit,
            atm_pkg::st_show_balance: begin
                next_state = atm_pkg::st_another;
            end
            atm_pkg::st_another: begin
                next_state = another ? atm_pkg::st_home : atm_pkg::st_eject;
            end
            atm_pkg::st_eject: begin
                next_state = atm_pkg::st_idle;
            end
            default: begin
                next_state = atm_pkg::st_idle;
            end
        endcase
        if (timer_abort) begin
            next_state = atm_pkg::st_eject; // timer beats everything
        end
    end

    // account latched once per session
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            sel_index <= '0;
        end else if (state == atm_pkg::st_card_check && lookup_hit) begin
            sel_index <= lookup_index;
        end
    end

    assign session_start = (state == atm_pkg::st_card_check);

    always_comb begin
        cmd = '0;
        status = '0;
        case (state)
            atm_pkg::st_withdraw_commit: begin
                cmd.write = 1'b1;
                status.withdrew = 1'b1;
            end
            atm_pkg::st_deposit_commit: begin
                cmd.write = 1'b1;
                cmd.is_deposit = 1'b1;
                status.deposited = 1'b1;
            end
            atm_pkg::st_show_balance: status.balance_shown = 1'b1;
            atm_pkg::st_eject:        status.usage_finished = 1'b1;
            default: begin
                cmd = '0;
                status = '0;
            end
        endcase
    end

    property one_status_at_a_time;
        @(posedge clk) disable iff (!reset)
        $onehot0(status);
    endproperty

    assert property (one_status_at_a_time)
        else $error("more than one status bit high");

    // pin guard must never both accept and lock out
    property pin_verdict_exclusive;
        @(posedge clk) disable iff (!reset)
        !(pin_ok && pin_locked);
    endproperty

    assert property (pin_verdict_exclusive)
        else $error("pin_ok and pin_locked high together");

endmodule

// ==== atm_top.sv ====
`timescale 1ns/1ps

module atm_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   card_in,
    input  logic                   timer,
    input  atm_pkg::card_number_t  card_number,
    input  atm_pkg::pin_t          pin,
    input  logic                   pin_strobe,
    input  atm_pkg::opcode_e       opcode,
    input  atm_pkg::money_t        amount,
    input  logic                   money_counted,
    input  logic                   another,
    output atm_pkg::atm_status_t   status,
    output atm_pkg::money_t        balance
);

    logic                  lookup_hit;
    atm_pkg::acct_index_t  lookup_index;
    atm_pkg::acct_index_t  sel_index;
    atm_pkg::ledger_cmd_t  cmd;
    atm_pkg::pin_t         stored_pin;
    logic                  withdraw_ok;
    logic                  deposit_ok;
    logic                  session_start;
    logic                  pin_ok;
    logic                  pin_locked;

    account_ledger ledger0 (
        .clk          (clk),
        .reset        (reset),
        .card_number  (card_number),
        .lookup_hit   (lookup_hit),
        .lookup_index (lookup_index),
        .sel_index    (sel_index),
        .amount       (amount),
        .cmd          (cmd),
        .stored_pin   (stored_pin),
        .balance      (balance),
        .withdraw_ok  (withdraw_ok),
        .deposit_ok   (deposit_ok)
    );

    pin_guard guard0 (
        .clk           (clk),
        .reset         (reset),
        .session_start (session_start),
        .pin_strobe    (pin_strobe),
        .pin           (pin),
        .stored_pin    (stored_pin),
        .pin_ok        (pin_ok),
        .pin_locked    (pin_locked)
    );

    session_fsm fsm0 (
        .clk           (clk),
        .reset         (reset),
        .card_in       (card_in),
        .timer         (timer),
        .opcode        (opcode),
        .money_counted (money_counted),
        .another       (another),
        .lookup_hit    (lookup_hit),
        .lookup_index  (lookup_index),
        .pin_ok        (pin_ok),
        .pin_locked    (pin_locked),
        .withdraw_ok   (withdraw_ok),
        .deposit_ok    (deposit_ok),
        .sel_index     (sel_index),
        .session_start (session_start),
        .cmd           (cmd),
        .status        (status)
    );

endmodule

// ==== tb_atm.sv ====
`timescale 1ns/1ps

module tb_atm;

    localparam int clk_period = 10;
    localparam int num_rows = 13;
    localparam int session_limit = 40;
    localparam int reset_cycles = 5;
    // room for a reset in front of every row
    localparam int watchdog_cycles = num_rows * session_limit + reset_cycles * (num_rows + 1);

    typedef enum logic [1:0] {
        pulse_none,
        pulse_balance,
        pulse_withdrew,
        pulse_deposited
    } pulse_e;

    typedef struct packed {
        atm_pkg::card_number_t card;
        logic [1:0]            wrong_pins;
        logic                  right_pin;
        atm_pkg::opcode_e      op;
        atm_pkg::money_t       amount;
        logic                  timer_abort;  // raise timer in st_deposit_wait
        logic                  another;      // follow up with a balance request
        logic                  do_reset;
        pulse_e                exp_pulse;
        atm_pkg::money_t       exp_balance;  // last balance shown in the session
    } session_row_t;

    logic                  clk;
    logic                  reset;
    logic                  card_in;
    logic                  timer;
    atm_pkg::card_number_t card_number;
    atm_pkg::pin_t         pin;
    logic                  pin_strobe;
    atm_pkg::opcode_e      opcode;
    atm_pkg::money_t       amount;
    logic                  money_counted;
    logic                  another;
    atm_pkg::atm_status_t  status;
    atm_pkg::money_t       balance;

    session_row_t    sessions [num_rows];
    atm_pkg::money_t model_bal [atm_pkg::num_accounts];

    int   cur_row;
    int   cur_idx;
    int   cycles;
    int   seen_balance;
    int   seen_withdrew;
    int   seen_deposited;
    logic finished;

    atm_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .card_in       (card_in),
        .timer         (timer),
        .card_number   (card_number),
        .pin           (pin),
        .pin_strobe    (pin_strobe),
        .opcode        (opcode),
        .amount        (amount),
        .money_counted (money_counted),
        .another       (another),
        .status        (status),
        .balance       (balance)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t ns: row %0d %s, got %0d, expected %0d",
                                $time, cur_row, what, actual, expected));
        end
    endtask

    task automatic fill_table();
        sessions[0]  = '{16'h1234, 2'd0, 1'b0, atm_pkg::op_none, 20'd0,
                         1'b0, 1'b0, 1'b0, pulse_none, 20'd0}; // unknown card
        sessions[1]  = '{16'hC5AA, 2'd0, 1'b1, atm_pkg::op_exit, 20'd0,
                         1'b0, 1'b0, 1'b0, pulse_none, 20'd0};
        sessions[2]  = '{16'h705C, 2'd3, 1'b0, atm_pkg::op_none, 20'd0,
                         1'b0, 1'b0, 1'b0, pulse_none, 20'd0}; // locked out
        sessions[3]  = '{16'h3219, 2'd2, 1'b1, atm_pkg::op_balance, 20'd0,
                         1'b0, 1'b0, 1'b0, pulse_balance, 20'd7500};
        sessions[4]  = '{16'hC5AA, 2'd0, 1'b1, atm_pkg::op_withdraw, 20'd1200,
                         1'b0, 1'b1, 1'b0, pulse_withdrew, 20'd3800};
        sessions[5]  = '{16'h8629, 2'd0, 1'b1, atm_pkg::op_withdraw, 20'd3001,
                         1'b0, 1'b0, 1'b0, pulse_none, 20'd0}; // short by one
        sessions[6]  = '{16'h8629, 2'd0, 1'b1, atm_pkg::op_balance, 20'd0,
                         1'b0, 1'b0, 1'b0, pulse_balance, 20'd3000};
        sessions[7]  = '{16'h705C, 2'd0, 1'b1, atm_pkg::op_deposit, 20'd2500,
                         1'b0, 1'b1, 1'b0, pulse_deposited, 20'd10500};
        sessions[8]  = '{16'hC5AA, 2'd0, 1'b1, atm_pkg::op_balance, 20'd0,
                         1'b0, 1'b0, 1'b0, pulse_balance, 20'd3800};
        sessions[9]  = '{16'h3219, 2'd0, 1'b1, atm_pkg::op_deposit, 20'd400,
                         1'b1, 1'b0, 1'b0, pulse_none, 20'd0}; // timer abort
        sessions[10] = '{16'h3219, 2'd0, 1'b1, atm_pkg::op_balance, 20'd0,
                         1'b0, 1'b0, 1'b0, pulse_balance, 20'd7500};
        sessions[11] = '{16'hC5AA, 2'd0, 1'b1, atm_pkg::op_balance, 20'd0,
                         1'b0, 1'b0, 1'b1, pulse_balance, 20'd5000};
        sessions[12] = '{16'h705C, 2'd0, 1'b1, atm_pkg::op_balance, 20'd0,
                         1'b0, 1'b0, 1'b0, pulse_balance, 20'd8000};
    endtask

    task automatic apply_reset();
        reset = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < atm_pkg::num_accounts; i++) begin
            model_bal[i] = atm_pkg::balance_reset_table[i];
        end
        check_value(status, '0, "status after reset");
    endtask

    // one falling edge, then look at what the last rising edge produced
    task automatic step_cycle();
        @(negedge clk);
        cycles++;
        if (status.balance_shown) begin
            seen_balance++;
            check_value(balance, model_bal[cur_idx], "balance shown");
            check_value(model_bal[cur_idx], sessions[cur_row].exp_balance, "model against table");
        end
        if (status.withdrew) seen_withdrew++;
        if (status.deposited) seen_deposited++;
        if (status.usage_finished) finished = 1'b1;
        if (!finished && cycles >= session_limit) begin
            abort_run($sformatf("row %0d: usage_finished did not arrive within %0d cycles",
                                cur_row, session_limit));
        end
    endtask

    task automatic run_session(input int r);
        session_row_t row;
        logic known;
        logic expect_ok;
        logic followup_sent;
        int shown_before;
        int exp_shown;
        row = sessions[r];
        cur_row = r;
        cur_idx = 0;
        cycles = 0;
        seen_balance = 0;
        seen_withdrew = 0;
        seen_deposited = 0;
        finished = 1'b0;
        followup_sent = 1'b0;
        shown_before = 0;
        known = 1'b0;
        for (int i = 0; i < atm_pkg::num_accounts; i++) begin
            if (atm_pkg::card_table[i] == row.card) begin
                cur_idx = i;
                known = 1'b1;
            end
        end
        if (row.do_reset) apply_reset();

        card_number = row.card;
        card_in = 1'b1;
        step_cycle();
        card_in = 1'b0;
        step_cycle(); // pin entry, or eject for an unknown card
        check_value(finished, !known, "eject right after card check");

        for (int i = 0; i < row.wrong_pins; i++) begin
            pin = atm_pkg::pin_table[cur_idx] ^ 16'h5a5a;
            pin_strobe = 1'b1;
            step_cycle();
            pin_strobe = 1'b0;
            check_value(finished, i + 1 >= atm_pkg::max_pin_tries, "eject after wrong pin");
        end

        if (row.right_pin) begin
            pin = atm_pkg::pin_table[cur_idx];
            pin_strobe = 1'b1;
            step_cycle();
            pin_strobe = 1'b0;
            check_value(finished, 1'b0, "card kept after right pin");
            opcode = row.op;
            amount = row.amount;
            step_cycle();
            opcode = atm_pkg::op_none;
            if (row.op == atm_pkg::op_withdraw) begin
                expect_ok = (row.amount <= model_bal[cur_idx]);
            end else begin
                expect_ok = (int'(model_bal[cur_idx]) + int'(row.amount)) < (1 << 20);
            end
            if (row.op == atm_pkg::op_withdraw || row.op == atm_pkg::op_deposit) begin
                check_value(expect_ok && !row.timer_abort, row.exp_pulse != pulse_none,
                            "table outcome against funds rule");
            end
            if (row.op == atm_pkg::op_deposit) begin
                if (row.timer_abort) begin
                    timer = 1'b1;
                    step_cycle();
                    timer = 1'b0;
                end else begin
                    step_cycle(); // counting takes a while
                    check_value(seen_deposited, 0, "deposit before money counted");
                    money_counted = 1'b1;
                    step_cycle();
                    money_counted = 1'b0;
                end
            end
            if (row.exp_pulse == pulse_withdrew) model_bal[cur_idx] -= row.amount;
            if (row.exp_pulse == pulse_deposited) model_bal[cur_idx] += row.amount;
        end

        another = row.another;
        while (!finished) begin
            if (row.another && !followup_sent
                    && (seen_balance + seen_withdrew + seen_deposited) > 0) begin
                opcode = atm_pkg::op_balance; // second transaction
                followup_sent = 1'b1;
                shown_before = seen_balance;
            end else if (followup_sent && seen_balance > shown_before) begin
                another = 1'b0;
                opcode = atm_pkg::op_none;
            end
            step_cycle();
        end
        another = 1'b0;
        opcode = atm_pkg::op_none;

        exp_shown = int'(row.exp_pulse == pulse_balance)
            + int'(row.another && row.exp_pulse != pulse_none);
        check_value(seen_balance, exp_shown, "balance_shown pulses");
        check_value(seen_withdrew, row.exp_pulse == pulse_withdrew, "withdrew pulses");
        check_value(seen_deposited, row.exp_pulse == pulse_deposited, "deposited pulses");
        @(negedge clk);
        check_value(status, '0, "status one cycle after eject");
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b0;
        card_in = 1'b0;
        timer = 1'b0;
        card_number = '0;
        pin = '0;
        pin_strobe = 1'b0;
        opcode = atm_pkg::op_none;
        amount = '0;
        money_counted = 1'b0;
        another = 1'b0;
        fill_table();
        apply_reset();
        for (int r = 0; r < num_rows; r++) begin
            run_session(r);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run($sformatf("watchdog expired after %0d cycles, the run hung", watchdog_cycles));
    end

endmodule

// ==== vlog.f ====
atm_pkg.sv
account_ledger.sv
pin_guard.sv
session_fsm.sv
atm_top.sv
tb_atm.sv
